// ==== id_params.svh ====
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

// datapath and address width
`define ID_XLEN      32

// general register file
`define ID_NREG      32
`define ID_REG_AW    5

// one-hot alu op, see isa_pkg for the bit order
`define ID_ALU_OPW   12

// bl writes its return address here
`define ID_LINK_REG  1

`endif

// ==== isa_pkg.sv ====
`default_nettype none

`include "id_params.svh"

package isa_pkg;

    typedef logic [`ID_XLEN-1:0]    word_t;
    typedef logic [`ID_REG_AW-1:0]  reg_addr_t;
    typedef logic [31:0]            inst_t;

    // bit 0 add .. 11 lui: add sub slt sltu and nor or xor sll srl sra lui
    typedef logic [`ID_ALU_OPW-1:0] alu_op_t;

    // 000 word, 001 half, 010 byte, msb set = unsigned load
    typedef logic [2:0]             mem_type_t;

    typedef struct packed {
        alu_op_t    alu_op;
        logic       src1_is_pc;
        logic       src2_is_imm;
        word_t      imm;
        logic       gr_we;
        reg_addr_t  dest;
        logic       st_w;
        logic       st_h;
        logic       st_b;
        logic       res_from_mem;
        mem_type_t  mem_type;
        reg_addr_t  raddr1;
        reg_addr_t  raddr2;
        logic       need_r1;
        logic       need_r2;
        logic       is_b;
        logic       is_bl;
        logic       is_jirl;
        logic       is_beq;
        logic       is_bne;
        logic       is_blt;
        logic       is_bge;
        logic       is_bltu;
        logic       is_bgeu;
        word_t      br_offs;    // already shifted left by two
    } decode_ctrl_t;

endpackage

`default_nettype wire

// ==== pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    // fetched instruction handed to ID
    typedef struct packed {
        isa_pkg::word_t     pc;
        isa_pkg::inst_t     inst;
    } if_id_t;

    // redirect back to IF
    typedef struct packed {
        logic               br_taken;
        isa_pkg::word_t     br_target;
    } id_if_t;

    typedef struct packed {
        logic                   gr_we;
        logic                   st_w;
        logic                   st_h;
        logic                   st_b;
        logic                   res_from_mem;
        isa_pkg::mem_type_t     mem_type;
        isa_pkg::alu_op_t       alu_op;
        isa_pkg::word_t         alu_src1;
        isa_pkg::word_t         alu_src2;
        isa_pkg::reg_addr_t     dest;
        isa_pkg::word_t         st_data;
        isa_pkg::word_t         pc;
    } id_ex_t;

    // bypass is only set when EX holds a valid reg-writing instruction
    typedef struct packed {
        logic                   bypass;
        logic                   is_load;    // wdata not ready yet
        isa_pkg::reg_addr_t     dest;
        isa_pkg::word_t         wdata;
    } ex_fwd_t;

    typedef struct packed {
        logic                   bypass;
        isa_pkg::reg_addr_t     dest;
        isa_pkg::word_t         wdata;
    } mem_fwd_t;

    // regfile write port, doubles as the WB forward
    typedef struct packed {
        logic                   we;
        isa_pkg::reg_addr_t     waddr;
        isa_pkg::word_t         wdata;
    } wb_fwd_t;

endpackage

`default_nettype wire

// ==== id_decoder.sv ====
`default_nettype none

`include "id_params.svh"

module id_decoder (
    input  isa_pkg::inst_t          inst,
    output isa_pkg::decode_ctrl_t   ctrl
);

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    isa_pkg::reg_addr_t rd, rj, rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;

    logic grp_3r, grp_sh;
    logic inst_add, inst_sub, inst_slt, inst_sltu, inst_nor, inst_and, inst_or, inst_xor;
    logic inst_sll, inst_srl, inst_sra;
    logic inst_slli, inst_srli, inst_srai;
    logic inst_addi, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
    logic inst_lu12i, inst_pcaddu12i;
    logic inst_ld_b, inst_ld_h, inst_ld_w, inst_ld_bu, inst_ld_hu;
    logic inst_st_b, inst_st_h, inst_st_w;
    logic inst_jirl, inst_b, inst_bl;
    logic inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;

    logic is_r_alu, is_i_alu, is_load, is_store, is_cond_br;
    logic need_ui5, need_si12, need_ui12, need_si20, need_si26, src2_is_4;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];

    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i20 = inst[24:5];
    assign i16 = inst[25:10];
    assign i26 = {inst[9:0], inst[25:10]};

    assign grp_3r = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign grp_sh = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);

    assign inst_add  = grp_3r && (op_19_15 == 5'h00);
    assign inst_sub  = grp_3r && (op_19_15 == 5'h02);
    assign inst_slt  = grp_3r && (op_19_15 == 5'h04);
    assign inst_sltu = grp_3r && (op_19_15 == 5'h05);
    assign inst_nor  = grp_3r && (op_19_15 == 5'h08);
    assign inst_and  = grp_3r && (op_19_15 == 5'h09);
    assign inst_or   = grp_3r && (op_19_15 == 5'h0a);
    assign inst_xor  = grp_3r && (op_19_15 == 5'h0b);
    assign inst_sll  = grp_3r && (op_19_15 == 5'h0e);
    assign inst_srl  = grp_3r && (op_19_15 == 5'h0f);
    assign inst_sra  = grp_3r && (op_19_15 == 5'h10);

    assign inst_slli = grp_sh && (op_19_15 == 5'h01);
    assign inst_srli = grp_sh && (op_19_15 == 5'h09);
    assign inst_srai = grp_sh && (op_19_15 == 5'h11);

    assign inst_slti  = (op_31_26 == 6'h00) && (op_25_22 == 4'h8);
    assign inst_sltui = (op_31_26 == 6'h00) && (op_25_22 == 4'h9);
    assign inst_addi  = (op_31_26 == 6'h00) && (op_25_22 == 4'ha);
    assign inst_andi  = (op_31_26 == 6'h00) && (op_25_22 == 4'hd);
    assign inst_ori   = (op_31_26 == 6'h00) && (op_25_22 == 4'he);
    assign inst_xori  = (op_31_26 == 6'h00) && (op_25_22 == 4'hf);

    assign inst_lu12i     = (op_31_26 == 6'h05) && !inst[25];
    assign inst_pcaddu12i = (op_31_26 == 6'h07) && !inst[25];

    assign inst_ld_b  = (op_31_26 == 6'h0a) && (op_25_22 == 4'h0);
    assign inst_ld_h  = (op_31_26 == 6'h0a) && (op_25_22 == 4'h1);
    assign inst_ld_w  = (op_31_26 == 6'h0a) && (op_25_22 == 4'h2);
    assign inst_st_b  = (op_31_26 == 6'h0a) && (op_25_22 == 4'h4);
    assign inst_st_h  = (op_31_26 == 6'h0a) && (op_25_22 == 4'h5);
    assign inst_st_w  = (op_31_26 == 6'h0a) && (op_25_22 == 4'h6);
    assign inst_ld_bu = (op_31_26 == 6'h0a) && (op_25_22 == 4'h8);
    assign inst_ld_hu = (op_31_26 == 6'h0a) && (op_25_22 == 4'h9);

    assign inst_jirl = (op_31_26 == 6'h13);
    assign inst_b    = (op_31_26 == 6'h14);
    assign inst_bl   = (op_31_26 == 6'h15);
    assign inst_beq  = (op_31_26 == 6'h16);
    assign inst_bne  = (op_31_26 == 6'h17);
    assign inst_blt  = (op_31_26 == 6'h18);
    assign inst_bge  = (op_31_26 == 6'h19);
    assign inst_bltu = (op_31_26 == 6'h1a);
    assign inst_bgeu = (op_31_26 == 6'h1b);

    assign is_r_alu = inst_add | inst_sub | inst_slt | inst_sltu | inst_nor | inst_and
                    | inst_or | inst_xor | inst_sll | inst_srl | inst_sra;
    assign is_i_alu = inst_slli | inst_srli | inst_srai | inst_addi | inst_slti | inst_sltui
                    | inst_andi | inst_ori | inst_xori;
    assign is_load    = inst_ld_b | inst_ld_h | inst_ld_w | inst_ld_bu | inst_ld_hu;
    assign is_store   = inst_st_b | inst_st_h | inst_st_w;
    assign is_cond_br = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;

    assign need_ui5  = inst_slli | inst_srli | inst_srai;
    assign need_si12 = inst_addi | inst_slti | inst_sltui | is_load | is_store;
    assign need_ui12 = inst_andi | inst_ori | inst_xori;
    assign need_si20 = inst_lu12i | inst_pcaddu12i;
    assign need_si26 = inst_b | inst_bl;
    assign src2_is_4 = inst_jirl | inst_bl;     // link value = pc + 4

    always_comb begin
        ctrl.alu_op[0]  = inst_add | inst_addi | is_load | is_store
                        | inst_jirl | inst_bl | inst_pcaddu12i;
        ctrl.alu_op[1]  = inst_sub;
        ctrl.alu_op[2]  = inst_slt  | inst_slti;
        ctrl.alu_op[3]  = inst_sltu | inst_sltui;
        ctrl.alu_op[4]  = inst_and  | inst_andi;
        ctrl.alu_op[5]  = inst_nor;
        ctrl.alu_op[6]  = inst_or   | inst_ori;
        ctrl.alu_op[7]  = inst_xor  | inst_xori;
        ctrl.alu_op[8]  = inst_sll  | inst_slli;
        ctrl.alu_op[9]  = inst_srl  | inst_srli;
        ctrl.alu_op[10] = inst_sra  | inst_srai;
        ctrl.alu_op[11] = inst_lu12i;

        ctrl.src1_is_pc  = inst_jirl | inst_bl | inst_pcaddu12i;
        ctrl.src2_is_imm = is_i_alu | is_load | is_store | need_si20 | src2_is_4;

        if (src2_is_4)
            ctrl.imm = 32'd4;
        else if (need_si20)
            ctrl.imm = {i20, 12'b0};
        else if (need_ui5)
            ctrl.imm = {27'b0, rk};
        else if (need_si12)
            ctrl.imm = {{20{i12[11]}}, i12};
        else if (need_ui12)
            ctrl.imm = {20'b0, i12};
        else
            ctrl.imm = '0;

        ctrl.gr_we = is_r_alu | is_i_alu | is_load | need_si20 | inst_jirl | inst_bl;
        ctrl.dest  = inst_bl ? isa_pkg::reg_addr_t'(`ID_LINK_REG) : rd;

        ctrl.st_w         = inst_st_w;
        ctrl.st_h         = inst_st_h;
        ctrl.st_b         = inst_st_b;
        ctrl.res_from_mem = is_load;
        ctrl.mem_type     = {inst_ld_hu | inst_ld_bu,
                             inst_ld_b | inst_ld_bu | inst_st_b,
                             inst_ld_h | inst_ld_hu | inst_st_h};

        // stores and compares read rd in place of rk
        ctrl.raddr1  = rj;
        ctrl.raddr2  = (is_store | is_cond_br) ? rd : rk;
        ctrl.need_r1 = is_r_alu | is_i_alu | is_load | is_store | is_cond_br | inst_jirl;
        ctrl.need_r2 = is_r_alu | is_store | is_cond_br;

        ctrl.is_b    = inst_b;
        ctrl.is_bl   = inst_bl;
        ctrl.is_jirl = inst_jirl;
        ctrl.is_beq  = inst_beq;
        ctrl.is_bne  = inst_bne;
        ctrl.is_blt  = inst_blt;
        ctrl.is_bge  = inst_bge;
        ctrl.is_bltu = inst_bltu;
        ctrl.is_bgeu = inst_bgeu;

        ctrl.br_offs = need_si26 ? {{4{i26[25]}}, i26, 2'b0}
                                 : {{14{i16[15]}}, i16, 2'b0};
    end

endmodule

`default_nettype wire

// ==== id_regfile.sv ====
`default_nettype none

`include "id_params.svh"

module id_regfile (
    input  logic                clk,
    input  isa_pkg::reg_addr_t  raddr1,
    output isa_pkg::word_t      rdata1,
    input  isa_pkg::reg_addr_t  raddr2,
    output isa_pkg::word_t      rdata2,
    input  logic                we,
    input  isa_pkg::reg_addr_t  waddr,
    input  isa_pkg::word_t      wdata
);

    isa_pkg::word_t regs [`ID_NREG];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 hardwired, same-cycle write comes in through the WB forward
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== id_operand_fwd.sv ====
`default_nettype none

module id_operand_fwd (
    input  isa_pkg::reg_addr_t  raddr1,
    input  isa_pkg::reg_addr_t  raddr2,
    input  logic                need_r1,
    input  logic                need_r2,
    input  isa_pkg::word_t      rf_rdata1,
    input  isa_pkg::word_t      rf_rdata2,
    input  pipe_pkg::ex_fwd_t   ex_fwd,
    input  pipe_pkg::mem_fwd_t  mem_fwd,
    input  pipe_pkg::wb_fwd_t   wb_fwd,
    output isa_pkg::word_t      rj_value,
    output isa_pkg::word_t      rkd_value,
    output logic                load_use_stall
);

    // a source in use that EX is about to write
    function automatic logic ex_hit(input isa_pkg::reg_addr_t addr, input logic need);
        return need && (addr != '0) && ex_fwd.bypass && (ex_fwd.dest == addr);
    endfunction

    // the youngest producer wins
    function automatic isa_pkg::word_t pick(input isa_pkg::reg_addr_t addr,
                                            input logic               need,
                                            input isa_pkg::word_t     rf_val);
        logic live;
        live = need && (addr != '0);
        if (ex_hit(addr, need))
            return ex_fwd.wdata;
        else if (live && mem_fwd.bypass && (mem_fwd.dest == addr))
            return mem_fwd.wdata;
        else if (live && wb_fwd.we && (wb_fwd.waddr == addr))
            return wb_fwd.wdata;
        else
            return rf_val;
    endfunction

    always_comb begin
        rj_value       = pick(raddr1, need_r1, rf_rdata1);
        rkd_value      = pick(raddr2, need_r2, rf_rdata2);
        // load data is not ready before MEM
        load_use_stall = ex_fwd.is_load
                       && (ex_hit(raddr1, need_r1) || ex_hit(raddr2, need_r2));
    end

endmodule

`default_nettype wire

// ==== id_branch_unit.sv ====
`default_nettype none

module id_branch_unit (
    input  isa_pkg::decode_ctrl_t   ctrl,
    input  isa_pkg::word_t          pc,
    input  isa_pkg::word_t          rj_value,
    input  isa_pkg::word_t          rkd_value,
    output logic                    taken,
    output isa_pkg::word_t          target
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (rj_value == rkd_value);
    assign lt_s = ($signed(rj_value) < $signed(rkd_value));
    assign lt_u = (rj_value < rkd_value);

    assign taken = ctrl.is_b | ctrl.is_bl | ctrl.is_jirl     // unconditional
                 | (ctrl.is_beq  &  eq)
                 | (ctrl.is_bne  & ~eq)
                 | (ctrl.is_blt  &  lt_s)
                 | (ctrl.is_bge  & ~lt_s)
                 | (ctrl.is_bltu &  lt_u)
                 | (ctrl.is_bgeu & ~lt_u);

    // jirl is register-relative, everything else pc-relative
    assign target = ctrl.is_jirl ? (rj_value + ctrl.br_offs) : (pc + ctrl.br_offs);

endmodule

`default_nettype wire

// ==== id_stage.sv ====
`default_nettype none

module id_stage (
    input  logic                clk,
    input  logic                resetn,

    input  logic                if_id_valid,
    output logic                id_allowin,
    input  pipe_pkg::if_id_t    if_id_bus,
    output pipe_pkg::id_if_t    id_if_bus,

    input  logic                ex_allowin,
    output logic                id_ex_valid,
    output pipe_pkg::id_ex_t    id_ex_bus,

    input  pipe_pkg::ex_fwd_t   ex_fwd,
    input  pipe_pkg::mem_fwd_t  mem_fwd,
    input  pipe_pkg::wb_fwd_t   wb_fwd
);

    logic                   id_valid;
    pipe_pkg::if_id_t       id_bus;     // instruction currently in ID
    isa_pkg::decode_ctrl_t  ctrl;
    isa_pkg::word_t         rf_rdata1, rf_rdata2;
    isa_pkg::word_t         rj_value, rkd_value;
    isa_pkg::word_t         br_target;
    logic                   br_cond;
    logic                   load_use_stall;
    logic                   ready_go;
    logic                   fire;
    logic                   br_fire;

    assign ready_go    = ~load_use_stall;
    assign id_ex_valid = id_valid & ready_go;
    assign fire        = id_ex_valid & ex_allowin;
    assign id_allowin  = ~id_valid | fire;
    assign br_fire     = fire & br_cond;    // redirect only as the branch leaves

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (br_fire) begin
            id_valid <= 1'b0;   // wrong-path fetch dropped
        end else if (id_allowin) begin
            id_valid <= if_id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_id_valid && id_allowin) begin
            id_bus <= if_id_bus;
        end
    end

    id_decoder u_decoder (
        .inst   (id_bus.inst),
        .ctrl   (ctrl)
    );

    id_regfile u_regfile (
        .clk    (clk),
        .raddr1 (ctrl.raddr1),
        .rdata1 (rf_rdata1),
        .raddr2 (ctrl.raddr2),
        .rdata2 (rf_rdata2),
        .we     (wb_fwd.we),
        .waddr  (wb_fwd.waddr),
        .wdata  (wb_fwd.wdata)
    );

    id_operand_fwd u_fwd (
        .raddr1         (ctrl.raddr1),
        .raddr2         (ctrl.raddr2),
        .need_r1        (ctrl.need_r1),
        .need_r2        (ctrl.need_r2),
        .rf_rdata1      (rf_rdata1),
        .rf_rdata2      (rf_rdata2),
        .ex_fwd         (ex_fwd),
        .mem_fwd        (mem_fwd),
        .wb_fwd         (wb_fwd),
        .rj_value       (rj_value),
        .rkd_value      (rkd_value),
        .load_use_stall (load_use_stall)
    );

    id_branch_unit u_branch (
        .ctrl       (ctrl),
        .pc         (id_bus.pc),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .taken      (br_cond),
        .target     (br_target)
    );

    assign id_if_bus.br_taken  = br_fire;
    assign id_if_bus.br_target = br_target;

    always_comb begin
        id_ex_bus.gr_we        = ctrl.gr_we;
        id_ex_bus.st_w         = ctrl.st_w;
        id_ex_bus.st_h         = ctrl.st_h;
        id_ex_bus.st_b         = ctrl.st_b;
        id_ex_bus.res_from_mem = ctrl.res_from_mem;
        id_ex_bus.mem_type     = ctrl.mem_type;
        id_ex_bus.alu_op       = ctrl.alu_op;
        id_ex_bus.alu_src1     = ctrl.src1_is_pc  ? id_bus.pc : rj_value;
        id_ex_bus.alu_src2     = ctrl.src2_is_imm ? ctrl.imm  : rkd_value;
        id_ex_bus.dest         = ctrl.dest;
        id_ex_bus.st_data      = rkd_value;     // rd value for stores
        id_ex_bus.pc           = id_bus.pc;
    end

endmodule

`default_nettype wire

// ==== tb_id_stage.sv ====
`default_nettype none

module tb_id_stage;

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic                   resetn;
        logic                   if_valid;
        logic [31:0]            pc;
        logic [31:0]            inst;
        logic                   ex_allowin;
        pipe_pkg::ex_fwd_t      ex_fwd;
        pipe_pkg::mem_fwd_t     mem_fwd;
        pipe_pkg::wb_fwd_t      wb_fwd;
        logic [2:0]             chk;        // 1 operands, 2 target, 4 store data
        logic                   exp_allowin;
        logic                   exp_ex_valid;
        logic [31:0]            exp_src1;
        logic [31:0]            exp_src2;
        logic [4:0]             exp_dest;
        logic                   exp_gr_we;
        logic [31:0]            exp_st_data;
        logic                   exp_br_taken;
        logic [31:0]            exp_br_target;
    } vec_t;

    logic               clk;
    logic               resetn;
    logic               if_id_valid;
    logic               id_allowin;
    pipe_pkg::if_id_t   if_id_bus;
    pipe_pkg::id_if_t   id_if_bus;
    logic               ex_allowin;
    logic               id_ex_valid;
    pipe_pkg::id_ex_t   id_ex_bus;
    pipe_pkg::ex_fwd_t  ex_fwd;
    pipe_pkg::mem_fwd_t mem_fwd;
    pipe_pkg::wb_fwd_t  wb_fwd;

    vec_t           vecs[$];
    int             errors;
    int             checks;
    logic           loaded;
    logic [31:0]    id_pc;      // pc of the instruction held in ID

    id_stage id_stage_i (
        .clk         (clk),
        .resetn      (resetn),
        .if_id_valid (if_id_valid),
        .id_allowin  (id_allowin),
        .if_id_bus   (if_id_bus),
        .id_if_bus   (id_if_bus),
        .ex_allowin  (ex_allowin),
        .id_ex_valid (id_ex_valid),
        .id_ex_bus   (id_ex_bus),
        .ex_fwd      (ex_fwd),
        .mem_fwd     (mem_fwd),
        .wb_fwd      (wb_fwd)
    );

    always #5 clk = ~clk;

    task automatic load_vectors();
        int          fd;
        int          n;
        int          cnt;
        int          line_no;
        string       line;
        logic [31:0] f [25];
        vec_t        v;
        fd = $fopen("id_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open id_stimulus.txt");
            errors++;
            return;
        end
        line_no = 0;
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            line_no++;
            if (n <= 1 || line.getc(0) == "#")
                continue;   // blank or comment
            cnt = $sscanf(line,
                          "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                          f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18],
                          f[19], f[20], f[21], f[22], f[23], f[24]);
            if (cnt != 25) begin
                $display("bad vector on line %0d of id_stimulus.txt: %0d fields instead of 25",
                         line_no, cnt);
                errors++;
                continue;
            end
            v.resetn         = f[0][0];
            v.if_valid       = f[1][0];
            v.pc             = f[2];
            v.inst           = f[3];
            v.ex_allowin     = f[4][0];
            v.ex_fwd.bypass  = f[5][0];
            v.ex_fwd.is_load = f[6][0];
            v.ex_fwd.dest    = f[7][4:0];
            v.ex_fwd.wdata   = f[8];
            v.mem_fwd.bypass = f[9][0];
            v.mem_fwd.dest   = f[10][4:0];
            v.mem_fwd.wdata  = f[11];
            v.wb_fwd.we      = f[12][0];
            v.wb_fwd.waddr   = f[13][4:0];
            v.wb_fwd.wdata   = f[14];
            v.chk            = f[15][2:0];
            v.exp_allowin    = f[16][0];
            v.exp_ex_valid   = f[17][0];
            v.exp_src1       = f[18];
            v.exp_src2       = f[19];
            v.exp_dest       = f[20][4:0];
            v.exp_gr_we      = f[21][0];
            v.exp_st_data    = f[22];
            v.exp_br_taken   = f[23][0];
            v.exp_br_target  = f[24];
            vecs.push_back(v);
        end
        $fclose(fd);
    endtask

    task automatic apply_vector(input vec_t v);
        resetn         <= v.resetn;
        if_id_valid    <= v.if_valid;
        if_id_bus.pc   <= v.pc;
        if_id_bus.inst <= v.inst;
        ex_allowin     <= v.ex_allowin;
        ex_fwd         <= v.ex_fwd;
        mem_fwd        <= v.mem_fwd;
        wb_fwd         <= v.wb_fwd;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp, input int idx);
        checks++;
        assert (got === exp)
        else begin
            $display("MISMATCH %s got %h expected %h at vector %0d", name, got, exp, idx);
            errors++;
        end
    endtask

    task automatic check_outputs(input vec_t v, input int idx, input logic [31:0] exp_pc);
        check_value("id_allowin", 32'(id_allowin), 32'(v.exp_allowin), idx);
        check_value("id_ex_valid", 32'(id_ex_valid), 32'(v.exp_ex_valid), idx);
        check_value("br_taken", 32'(id_if_bus.br_taken), 32'(v.exp_br_taken), idx);
        if (v.chk[0]) begin
            check_value("alu_src1", id_ex_bus.alu_src1, v.exp_src1, idx);
            check_value("alu_src2", id_ex_bus.alu_src2, v.exp_src2, idx);
            check_value("dest", 32'(id_ex_bus.dest), 32'(v.exp_dest), idx);
            check_value("gr_we", 32'(id_ex_bus.gr_we), 32'(v.exp_gr_we), idx);
            check_value("pc", id_ex_bus.pc, exp_pc, idx);
        end
        if (v.chk[1])
            check_value("br_target", id_if_bus.br_target, v.exp_br_target, idx);
        if (v.chk[2])
            check_value("st_data", id_ex_bus.st_data, v.exp_st_data, idx);
    endtask

    initial begin
        clk         = 1'b0;
        resetn      <= 1'b0;
        if_id_valid <= 1'b0;
        if_id_bus   <= '0;
        ex_allowin  <= 1'b0;
        ex_fwd      <= '0;
        mem_fwd     <= '0;
        wb_fwd      <= '0;
        errors      = 0;
        checks      = 0;
        loaded      = 1'b0;
        id_pc       = '0;
        load_vectors();
        if (vecs.size() == 0) begin
            $display("no vectors were read from id_stimulus.txt");
            errors++;
        end
        loaded = 1'b1;
        foreach (vecs[i]) begin
            @(posedge clk);
            apply_vector(vecs[i]);
            @(negedge clk);     // outputs settled
            check_outputs(vecs[i], i, id_pc);
            // taken into ID at the next edge unless a taken branch drops it
            if (vecs[i].resetn && vecs[i].if_valid && vecs[i].exp_allowin
                    && !vecs[i].exp_br_taken)
                id_pc = vecs[i].pc;
        end
        @(posedge clk);
        $display("vectors %0d checks %0d errors %0d", vecs.size(), checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // run length follows the vector count
    initial begin
        int limit_ns;
        wait (loaded);
        limit_ns = vecs.size() * 10 + 200;
        #(limit_ns);
        $display("watchdog expired after %0d ns before the vectors were done", limit_ns);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== id_stage.f ====
+incdir+.
isa_pkg.sv
pipe_pkg.sv
id_decoder.sv
id_regfile.sv
id_operand_fwd.sv
id_branch_unit.sv
id_stage.sv
tb_id_stage.sv

// ==== run.sh ====
#!/bin/sh
# builds the id_stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f id_stage.f --top-module tb_id_stage -o sim_id_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_id_stage > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// ==== id_stimulus.txt ====
# rstn ifv pc inst exa | ex: byp ld dst data | mem: byp dst data | wb: we addr data | chk
# exp: allowin exvalid src1 src2 dest grwe stdata brtaken brtarget   (chk 1 ops, 2 target, 4 st)
0 0 00000000 00000000 1 0 0 00 00000000 0 00 00000000 0 00 00000000 0 1 0 00000000 00000000 00 0 00000000 0 00000000
0 0 00000000 00000000 1 0 0 00 00000000 0 00 00000000 0 00 00000000 0 1 0 00000000 00000000 00 0 00000000 0 00000000
0 0 00000000 00000000 1 0 0 00 00000000 0 00 00000000 0 00 00000000 0 1 0 00000000 00000000 00 0 00000000 0 00000000
0 0 00000000 00000000 1 0 0 00 00000000 0 00 00000000 0 00 00000000 0 1 0 00000000 00000000 00 0 00000000 0 00000000
0 0 00000000 00000000 1 0 0 00 00000000 0 00 00000000 0 00 00000000 0 1 0 00000000 00000000 00 0 00000000 0 00000000
1 0 00000000 00000000 1 0 0 00 00000000 0 00 00000000 1 01 00000010 0 1 0 00000000 00000000 00 0 00000000 0 00000000
1 0 00000000 00000000 1 0 0 00 00000000 0 00 00000000 1 02 00000020 0 1 0 00000000 00000000 00 0 00000000 0 00000000
1 0 00000000 00000000 1 0 0 00 00000000 0 00 00000000 1 04 80000000 0 1 0 00000000 00000000 00 0 00000000 0 00000000
1 0 00000000 00000000 1 0 0 00 00000000 0 00 00000000 1 05 00000005 0 1 0 00000000 00000000 00 0 00000000 0 00000000
1 1 00001000 00100823 1 0 0 00 00000000 0 00 00000000 1 00 deadbeef 0 1 0 00000000 00000000 00 0 00000000 0 00000000
1 1 00001004 00100806 1 0 0 00 00000000 0 00 00000000 0 00 00000000 5 1 1 00000010 00000020 03 1 00000020 0 00000000
1 1 00001008 02bff027 1 1 0 00 12345678 0 00 00000000 0 00 00000000 5 1 1 00000000 00000020 06 1 00000020 0 00000000
1 1 0000100c 03600088 1 0 0 00 00000000 0 00 00000000 0 00 00000000 1 1 1 00000010 fffffffc 07 1 00000000 0 00000000
1 1 00001010 00409ca9 1 0 0 00 00000000 0 00 00000000 0 00 00000000 1 1 1 80000000 00000800 08 1 00000000 0 00000000
1 1 00001014 1500002a 1 0 0 00 00000000 0 00 00000000 0 00 00000000 1 1 1 00000005 00000007 09 1 00000000 0 00000000
1 1 00001018 29802022 1 0 0 00 00000000 0 00 00000000 0 00 00000000 1 1 1 00000010 80001000 0a 1 00000000 0 00000000
1 1 0000101c 001008ab 1 0 0 00 00000000 0 00 00000000 0 00 00000000 5 1 1 00000010 00000008 02 0 00000020 0 00000000
1 1 00001020 001004ac 0 1 0 05 eeee0001 1 05 aaaa0002 1 05 bbbb0003 5 0 1 eeee0001 00000020 0b 1 00000020 0 00000000
1 1 00001020 001004ac 0 0 0 00 00000000 1 05 aaaa0002 1 05 bbbb0003 5 0 1 aaaa0002 00000020 0b 1 00000020 0 00000000
1 1 00001020 001004ac 1 0 0 00 00000000 0 00 00000000 1 05 bbbb0003 5 1 1 bbbb0003 00000020 0b 1 00000020 0 00000000
1 1 00001024 58001021 1 1 1 05 00000000 0 00 00000000 0 00 00000000 0 0 0 00000000 00000000 00 0 00000000 0 00000000
1 1 00001024 58001021 1 1 1 05 00000000 0 00 00000000 0 00 00000000 0 0 0 00000000 00000000 00 0 00000000 0 00000000
1 1 00001024 58001021 1 0 0 00 00000000 1 05 0c0c0c0c 0 00 00000000 5 1 1 0c0c0c0c 00000010 0c 1 00000010 0 00000000
1 1 00001028 00100823 1 0 0 00 00000000 0 00 00000000 0 00 00000000 3 1 1 00000010 00000010 01 0 00000000 1 00001034
1 1 00001034 5c002022 1 0 0 00 00000000 0 00 00000000 0 00 00000000 0 1 0 00000000 00000000 00 0 00000000 0 00000000
1 1 00001038 00100823 1 0 0 00 00000000 0 00 00000000 0 00 00000000 3 1 1 00000010 00000020 02 0 00000000 1 00001054
1 1 00001054 63fff881 1 0 0 00 00000000 0 00 00000000 0 00 00000000 0 1 0 00000000 00000000 00 0 00000000 0 00000000
1 1 00001058 00100823 1 0 0 00 00000000 0 00 00000000 0 00 00000000 3 1 1 80000000 00000010 01 0 00000000 1 0000104c
1 1 0000104c 68001081 1 0 0 00 00000000 0 00 00000000 0 00 00000000 0 1 0 00000000 00000000 00 0 00000000 0 00000000
1 1 00001050 6c001081 1 0 0 00 00000000 0 00 00000000 0 00 00000000 3 1 1 80000000 00000010 01 0 00000000 0 0000105c
1 1 00001054 00100823 1 0 0 00 00000000 0 00 00000000 0 00 00000000 3 1 1 80000000 00000010 01 0 00000000 1 00001060
1 1 00001060 58001022 1 0 0 00 00000000 0 00 00000000 0 00 00000000 0 1 0 00000000 00000000 00 0 00000000 0 00000000
1 1 00001064 4c001041 1 0 0 00 00000000 0 00 00000000 0 00 00000000 3 1 1 00000010 00000020 02 0 00000000 0 00001070
1 1 00001068 00100823 1 0 0 00 00000000 0 00 00000000 0 00 00000000 3 1 1 00001064 00000004 01 1 00000000 1 00000030
1 1 00000030 54002000 1 0 0 00 00000000 0 00 00000000 0 00 00000000 0 1 0 00000000 00000000 00 0 00000000 0 00000000
1 1 00000034 00100823 1 0 0 00 00000000 0 00 00000000 0 00 00000000 3 1 1 00000030 00000004 01 1 00000000 1 00000050
1 1 00000050 00100823 1 0 0 00 00000000 0 00 00000000 0 00 00000000 0 1 0 00000000 00000000 00 0 00000000 0 00000000
1 1 00000054 00100806 0 0 0 00 00000000 0 00 00000000 0 00 00000000 1 0 1 00000010 00000020 03 1 00000000 0 00000000
1 1 00000054 00100806 0 0 0 00 00000000 0 00 00000000 0 00 00000000 1 0 1 00000010 00000020 03 1 00000000 0 00000000
1 1 00000054 00100806 1 0 0 00 00000000 0 00 00000000 0 00 00000000 1 1 1 00000010 00000020 03 1 00000000 0 00000000
1 0 00000000 00000000 1 0 0 00 00000000 0 00 00000000 0 00 00000000 1 1 1 00000000 00000020 06 1 00000000 0 00000000
1 0 00000000 00000000 1 0 0 00 00000000 0 00 00000000 0 00 00000000 0 1 0 00000000 00000000 00 0 00000000 0 00000000
